//--- compile.f
fetch_pkg.sv
fetch_pc.sv
icache_array.sv
fetch_ctrl.sv
if2_reg.sv
fetch_top.sv
tb_fetch.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_fetch -f compile.f -o sim_fetch

out=$(./obj_dir/sim_fetch || true)
echo "$out"

if grep -q "Result: PASSED" <<< "$out"; then
    exit 0
fi
exit 1

//--- tb_fetch.sv
module tb_fetch;

    localparam logic [63:0] RESET_PC = 64'h0000_0000_3000_0000;
    localparam logic [63:0] ERR_BASE = 64'h0000_0000_3000_0400; // 64-byte window that faults.
    localparam int          TIMEOUT  = 400;

    logic             clk;
    logic             rst;
    logic             stall;
    logic             redirect;
    logic [63:0]      redirect_pc;
    logic             mem_rvalid;
    logic [63:0]      mem_rdata;
    logic             mem_err;
    logic             mem_req;
    logic [63:0]      mem_addr;
    logic [63:0]      if2_pc;
    logic [63:0]      if2_word;
    logic [7:0]       if2_hit;
    logic             if2_valid;
    fetch_pkg::trap_e if2_trap;

    // The scoreboard holds cache contents by way, the expected address and every valid entry seen.
    logic [63:0]      model_addr [8];
    logic [7:0]       model_valid;
    int               fill_count;
    logic [63:0]      exp_pc;
    logic [63:0]      ent_pc [$];
    logic [7:0]       ent_hit [$];
    fetch_pkg::trap_e ent_trap [$];
    string            test_name;

    logic [31:0]      mem_seed;
    logic [31:0]      stim_seed;
    int               pend_cnt;
    logic [63:0]      pend_addr;
    int               req_count;
    logic [63:0]      last_req_addr;

    logic             stall_q;
    logic             redirect_q;
    logic [63:0]      redirect_pc_q;
    logic [63:0]      hold_pc;
    logic [63:0]      hold_word;
    logic [7:0]       hold_hit;
    logic             hold_valid;
    fetch_pkg::trap_e hold_trap;

    fetch_top #(
        .RESET_PC(RESET_PC)
    ) UUT (
        .clk        (clk),
        .rst        (rst),
        .stall      (stall),
        .redirect   (redirect),
        .redirect_pc(redirect_pc),
        .mem_rvalid (mem_rvalid),
        .mem_rdata  (mem_rdata),
        .mem_err    (mem_err),
        .mem_req    (mem_req),
        .mem_addr   (mem_addr),
        .if2_pc     (if2_pc),
        .if2_word   (if2_word),
        .if2_hit    (if2_hit),
        .if2_valid  (if2_valid),
        .if2_trap   (if2_trap)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Memory contents are the word address XORed with a constant, then rotated left by 13.
    function automatic logic [63:0] mem_word(input logic [63:0] addr);
        logic [63:0] x;
        x = {addr[63:3], 3'b000} ^ 64'hA5C3_0F96_5A3C_F069;
        return {x[50:0], x[63:51]};
    endfunction

    function automatic logic in_err_window(input logic [63:0] addr);
        return (addr >= ERR_BASE) && (addr < ERR_BASE + 64'd64);
    endfunction

    function automatic fetch_pkg::trap_e expected_trap(input logic [63:0] addr);
        if (addr[1:0] != 2'b00) begin
            return fetch_pkg::TRAP_MISALIGN;
        end
        if (in_err_window(addr)) begin
            return fetch_pkg::TRAP_ACCESS; // Faulting words are never filled.
        end
        return fetch_pkg::TRAP_NOP;
    endfunction

    function automatic int model_way(input logic [63:0] addr);
        for (int w = 0; w < 8; w++) begin
            if (model_valid[w] && model_addr[w] == {addr[63:3], 3'b000}) begin
                return w;
            end
        end
        return -1;
    endfunction

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("Result: FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_word(input string what, input logic [63:0] exp, input logic [63:0] act);
        if (act !== exp) begin
            stop_with_error($sformatf("Mismatch in %s, %s: expected %h, actual %h",
                                      test_name, what, exp, act));
        end
    endtask

    task automatic check_hit(input string what, input logic [7:0] exp, input logic [7:0] act);
        if (act !== exp) begin
            stop_with_error($sformatf("Mismatch in %s, %s: expected %b, actual %b",
                                      test_name, what, exp, act));
        end
    endtask

    task automatic check_bit(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            stop_with_error($sformatf("Mismatch in %s, %s: expected %b, actual %b",
                                      test_name, what, exp, act));
        end
    endtask

    task automatic check_trap(input string what, input fetch_pkg::trap_e exp,
                              input fetch_pkg::trap_e act);
        if (act !== exp) begin
            stop_with_error($sformatf("Mismatch in %s, %s: expected %s, actual %s (%0d)",
                                      test_name, what, exp.name(), act.name(), act));
        end
    endtask

    task automatic check_entry();
        fetch_pkg::trap_e exp_trap;
        logic [63:0]      exp_word;
        logic [7:0]       exp_hit;
        int               way;
        check_word("pc", exp_pc, if2_pc);
        exp_trap = expected_trap(exp_pc);
        exp_word = '0;
        exp_hit  = '0;
        if (exp_trap == fetch_pkg::TRAP_NOP) begin
            way = model_way(exp_pc);
            if (way < 0) begin
                stop_with_error("A valid fetch entry came from a word that was never filled.");
            end else begin
                exp_hit  = 8'b1 << way;
                exp_word = mem_word(exp_pc);
            end
        end
        check_trap("trap", exp_trap, if2_trap);
        check_hit("hit", exp_hit, if2_hit);
        check_word("word", exp_word, if2_word);
        ent_pc.push_back(if2_pc);
        ent_hit.push_back(if2_hit);
        ent_trap.push_back(if2_trap);
        exp_pc = exp_pc + 64'd4;
    endtask

    always @(posedge clk) begin
        stall_q       <= stall;
        redirect_q    <= redirect;
        redirect_pc_q <= redirect_pc;
    end

    // Memory model with a random latency of 1 to 6 cycles.
    always @(negedge clk) begin
        mem_rvalid = 1'b0;
        mem_err    = 1'b0;
        if (pend_cnt > 0) begin
            pend_cnt--;
            if (pend_cnt == 0) begin
                mem_rvalid = 1'b1;
                mem_rdata  = mem_word(pend_addr);
                mem_err    = in_err_window(pend_addr);
                if (!mem_err) begin
                    model_addr[fill_count % 8]  = pend_addr; // Fill k goes to way k mod 8.
                    model_valid[fill_count % 8] = 1'b1;
                    fill_count++;
                end
            end
        end
        if (mem_req) begin
            if (pend_cnt > 0) begin
                stop_with_error("A memory request arrived while another was outstanding.");
            end else begin
                mem_seed      = lcg_step(mem_seed);
                pend_cnt      = 1 + int'(mem_seed[31:16] % 16'd6);
                pend_addr     = mem_addr;
                last_req_addr = mem_addr;
                req_count++;
            end
        end
    end

    // Compares the stage register after every rising edge.
    always @(negedge clk) begin
        if (stall_q) begin
            check_word("held pc", hold_pc, if2_pc);
            check_word("held word", hold_word, if2_word);
            check_hit("held hit", hold_hit, if2_hit);
            check_bit("held valid", hold_valid, if2_valid);
            check_trap("held trap", hold_trap, if2_trap);
        end else if (if2_valid) begin
            check_entry();
        end
        if (redirect_q) begin
            exp_pc = redirect_pc_q;
        end
        hold_pc    = if2_pc;
        hold_word  = if2_word;
        hold_hit   = if2_hit;
        hold_valid = if2_valid;
        hold_trap  = if2_trap;
    end

    task automatic wait_entries(input int target);
        int cycles;
        cycles = 0;
        @(posedge clk);
        while (ent_pc.size() < target && cycles < TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        if (ent_pc.size() < target) begin
            stop_with_error("Timed out waiting for valid fetch entries.");
        end
    endtask

    task automatic await_pc(input logic [63:0] target, input int from, output int idx);
        int cycles;
        idx    = -1;
        cycles = 0;
        while (idx < 0 && cycles < TIMEOUT) begin
            @(posedge clk);
            cycles++;
            for (int i = from; i < ent_pc.size(); i++) begin
                if (idx < 0 && ent_pc[i] == target) begin
                    idx = i;
                end
            end
        end
        if (idx < 0) begin
            stop_with_error($sformatf("No fetch entry for address %h arrived in time.", target));
        end
    endtask

    task automatic await_request(input int base, input logic [63:0] addr);
        int cycles;
        cycles = 0;
        @(posedge clk);
        while (!(req_count > base && last_req_addr == addr) && cycles < TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        if (!(req_count > base && last_req_addr == addr)) begin
            stop_with_error($sformatf("No memory request for address %h was seen.", addr));
        end
    endtask

    task automatic pulse_redirect(input logic [63:0] target);
        @(negedge clk);
        redirect    = 1'b1;
        redirect_pc = target;
        @(negedge clk);
        redirect = 1'b0;
    endtask

    initial begin
        int idx;
        int base;
        clk         = 1'b0;
        rst         = 1'b1;
        stall       = 1'b0;
        redirect    = 1'b0;
        redirect_pc = '0;
        mem_rvalid  = 1'b0;
        mem_rdata   = '0;
        mem_err     = 1'b0;
        model_valid = '0;
        fill_count  = 0;
        exp_pc      = RESET_PC;
        mem_seed    = 32'h5315_7224;
        stim_seed   = 32'h5315_7224;
        pend_cnt    = 0;
        req_count   = 0;
        test_name   = "reset";
        repeat (3) @(negedge clk);
        rst = 1'b0;

        test_name = "reset_first_fetch";
        check_bit("valid after reset", 1'b0, if2_valid);
        check_word("pc after reset", RESET_PC, if2_pc);
        wait_entries(2);
        check_word("request count", 64'd1, 64'(req_count));
        check_word("request address", RESET_PC, last_req_addr);
        check_hit("first hit", 8'h01, ent_hit[0]);

        test_name = "sequential_wrap";
        wait_entries(24);
        for (int k = 0; k < 12; k++) begin
            check_hit("way of word", 8'b1 << (k % 8), ent_hit[2 * k]);
        end
        base = req_count;
        pulse_redirect(RESET_PC); // Word 0 was evicted by word 8.
        await_request(base, RESET_PC);

        test_name = "random_stall";
        await_pc(RESET_PC, 24, idx);
        repeat (150) begin
            @(negedge clk);
            stim_seed = lcg_step(stim_seed);
            stall     = stim_seed[31];
        end
        @(negedge clk);
        stall = 1'b0;
        @(posedge clk);
        wait_entries(ent_pc.size() + 6);

        test_name = "misaligned_redirect";
        base = ent_pc.size();
        pulse_redirect(RESET_PC + 64'h102);
        await_pc(RESET_PC + 64'h102, base, idx);
        check_trap("first trap", fetch_pkg::TRAP_MISALIGN, ent_trap[idx]);
        check_hit("trap hit", 8'h00, ent_hit[idx]);
        wait_entries(idx + 2);
        check_word("pc after trap", RESET_PC + 64'h106, ent_pc[idx + 1]);

        test_name = "access_fault";
        base = ent_pc.size();
        pulse_redirect(ERR_BASE);
        await_pc(ERR_BASE, base, idx);
        check_trap("fault trap", fetch_pkg::TRAP_ACCESS, ent_trap[idx]);
        base = req_count;
        await_request(base, ERR_BASE); // The faulting word was not cached, so it is read again.

        test_name = "redirect_during_refill";
        base = req_count;
        await_request(base, ERR_BASE + 64'd8);
        base = ent_pc.size();
        pulse_redirect(RESET_PC + 64'h800);
        await_pc(RESET_PC + 64'h800, base, idx);
        check_word("first entry after redirect", RESET_PC + 64'h800, ent_pc[base]);
        check_trap("trap after redirect", fetch_pkg::TRAP_NOP, ent_trap[idx]);
        wait_entries(idx + 3);

        $display("Result: PASSED");
        $finish;
    end

endmodule

//--- fetch_top.sv
module fetch_top #(
    parameter logic [fetch_pkg::ADDR_W-1:0] RESET_PC = 64'h0000_0000_3000_0000
) (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            stall,
    input  logic                            redirect,
    input  logic [fetch_pkg::ADDR_W-1:0]    redirect_pc,
    input  logic                            mem_rvalid,
    input  logic [fetch_pkg::WORD_W-1:0]    mem_rdata,
    input  logic                            mem_err,
    output logic                            mem_req,
    output logic [fetch_pkg::ADDR_W-1:0]    mem_addr,
    output logic [fetch_pkg::ADDR_W-1:0]    if2_pc,
    output logic [fetch_pkg::WORD_W-1:0]    if2_word,
    output logic [fetch_pkg::NUM_WAYS-1:0]  if2_hit,
    output logic                            if2_valid,
    output fetch_pkg::trap_e                if2_trap
);

    logic [fetch_pkg::ADDR_W-1:0]   pc;
    logic [fetch_pkg::NUM_WAYS-1:0] hit;
    logic [fetch_pkg::WORD_W-1:0]   rd_word;
    logic                           pc_advance;
    logic                           fill_en;
    logic                           reg_enable;
    logic                           reg_valid;
    fetch_pkg::trap_e               reg_trap;

    fetch_pc #(
        .RESET_PC(RESET_PC)
    ) u_pc (
        .clk        (clk),
        .rst        (rst),
        .pc_advance (pc_advance),
        .redirect   (redirect),
        .redirect_pc(redirect_pc),
        .pc         (pc)
    );

    // The fill tag follows the request address, since pc may have moved on a redirect.
    icache_array u_cache (
        .clk      (clk),
        .rst      (rst),
        .pc       (pc),
        .hit      (hit),
        .rd_word  (rd_word),
        .fill_en  (fill_en),
        .fill_tag (mem_addr[fetch_pkg::ADDR_W-1:3]),
        .fill_word(mem_rdata)
    );

    fetch_ctrl u_ctrl (
        .clk       (clk),
        .rst       (rst),
        .pc        (pc),
        .hit       (hit),
        .stall     (stall),
        .redirect  (redirect),
        .mem_rvalid(mem_rvalid),
        .mem_err   (mem_err),
        .mem_req   (mem_req),
        .mem_addr  (mem_addr),
        .fill_en   (fill_en),
        .pc_advance(pc_advance),
        .reg_enable(reg_enable),
        .reg_valid (reg_valid),
        .reg_trap  (reg_trap)
    );

    if2_reg #(
        .RESET_PC(RESET_PC)
    ) u_if2 (
        .clk      (clk),
        .rst      (rst),
        .enable   (reg_enable),
        .pc_in    (pc),
        .word_in  (rd_word),
        .hit_in   (hit),
        .valid_in (reg_valid),
        .trap_in  (reg_trap),
        .pc_out   (if2_pc),
        .word_out (if2_word),
        .hit_out  (if2_hit),
        .valid_out(if2_valid),
        .trap_out (if2_trap)
    );

endmodule

//--- if2_reg.sv
module if2_reg #(
    parameter logic [fetch_pkg::ADDR_W-1:0] RESET_PC = 64'h0000_0000_3000_0000
) (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            enable,
    input  logic [fetch_pkg::ADDR_W-1:0]    pc_in,
    input  logic [fetch_pkg::WORD_W-1:0]    word_in,
    input  logic [fetch_pkg::NUM_WAYS-1:0]  hit_in,
    input  logic                            valid_in,
    input  fetch_pkg::trap_e                trap_in,
    output logic [fetch_pkg::ADDR_W-1:0]    pc_out,
    output logic [fetch_pkg::WORD_W-1:0]    word_out,
    output logic [fetch_pkg::NUM_WAYS-1:0]  hit_out,
    output logic                            valid_out,
    output fetch_pkg::trap_e                trap_out
);

    // Every field loads together, or every field holds.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc_out    <= RESET_PC;
            word_out  <= '0;
            hit_out   <= '0;
            valid_out <= 1'b0;
            trap_out  <= fetch_pkg::TRAP_NOP;
        end else if (enable) begin
            pc_out    <= pc_in;
            word_out  <= word_in;
            hit_out   <= hit_in;
            valid_out <= valid_in;
            trap_out  <= trap_in;
        end
    end

endmodule

//--- fetch_ctrl.sv
module fetch_ctrl (
    input  logic                            clk,
    input  logic                            rst,
    input  logic [fetch_pkg::ADDR_W-1:0]    pc,
    input  logic [fetch_pkg::NUM_WAYS-1:0]  hit,
    input  logic                            stall,
    input  logic                            redirect,
    input  logic                            mem_rvalid,
    input  logic                            mem_err,
    output logic                            mem_req,
    output logic [fetch_pkg::ADDR_W-1:0]    mem_addr,
    output logic                            fill_en,
    output logic                            pc_advance,
    output logic                            reg_enable,
    output logic                            reg_valid,
    output fetch_pkg::trap_e                reg_trap
);

    fetch_pkg::ctrl_state_e state;
    fetch_pkg::ctrl_state_e state_next;

    logic redir_seen; // Set when a redirect lands while a refill is outstanding.
    logic misaligned;
    logic any_hit;
    logic start_refill;
    logic refill_err;

    assign misaligned = (pc[1:0] != 2'b00);
    assign any_hit    = |hit;

    assign start_refill = (state == fetch_pkg::ST_LOOKUP) && !redirect && !misaligned && !any_hit;

    // An error that belongs to a fetch abandoned by a redirect is dropped.
    assign refill_err = (state == fetch_pkg::ST_WAIT) && mem_rvalid && mem_err
                        && !redir_seen && !redirect;

    always_comb begin
        state_next = state;
        pc_advance = 1'b0;
        reg_valid  = 1'b0;
        reg_trap   = fetch_pkg::TRAP_NOP;
        case (state)
            fetch_pkg::ST_LOOKUP: begin
                if (start_refill) begin
                    state_next = fetch_pkg::ST_REQ;
                end else if (!redirect && misaligned) begin
                    reg_valid  = 1'b1;
                    reg_trap   = fetch_pkg::TRAP_MISALIGN;
                    pc_advance = !stall;
                end else if (!redirect) begin
                    reg_valid  = 1'b1;
                    pc_advance = !stall;
                end
            end
            fetch_pkg::ST_REQ: begin
                state_next = fetch_pkg::ST_WAIT;
            end
            fetch_pkg::ST_WAIT: begin
                if (mem_rvalid) begin
                    state_next = fetch_pkg::ST_LOOKUP;
                    // Under stall the failed lookup is simply repeated later.
                    if (refill_err) begin
                        reg_valid  = 1'b1;
                        reg_trap   = fetch_pkg::TRAP_ACCESS;
                        pc_advance = !stall;
                    end
                end
            end
            default: begin
                state_next = fetch_pkg::ST_LOOKUP;
            end
        endcase
    end

    assign reg_enable = !stall;
    assign mem_req    = (state == fetch_pkg::ST_REQ);
    assign fill_en    = (state == fetch_pkg::ST_WAIT) && mem_rvalid && !mem_err;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= fetch_pkg::ST_LOOKUP;
            redir_seen <= 1'b0;
            mem_addr   <= '0;
        end else begin
            state <= state_next;
            if (start_refill) begin
                mem_addr <= {pc[fetch_pkg::ADDR_W-1:3], 3'b000}; // Held until the response.
            end
            if (state_next == fetch_pkg::ST_LOOKUP) begin
                redir_seen <= 1'b0;
            end else if (redirect) begin
                redir_seen <= 1'b1;
            end
        end
    end

endmodule

//--- icache_array.sv
module icache_array (
    input  logic                            clk,
    input  logic                            rst,
    input  logic [fetch_pkg::ADDR_W-1:0]    pc,
    output logic [fetch_pkg::NUM_WAYS-1:0]  hit,
    output logic [fetch_pkg::WORD_W-1:0]    rd_word,
    input  logic                            fill_en,
    input  logic [fetch_pkg::TAG_W-1:0]     fill_tag,
    input  logic [fetch_pkg::WORD_W-1:0]    fill_word
);

    localparam int PTR_W = $clog2(fetch_pkg::NUM_WAYS);

    logic [fetch_pkg::NUM_WAYS-1:0] way_valid;
    logic [fetch_pkg::TAG_W-1:0]    way_tag  [fetch_pkg::NUM_WAYS];
    logic [fetch_pkg::WORD_W-1:0]   way_data [fetch_pkg::NUM_WAYS];
    logic [PTR_W-1:0]               victim;
    logic [fetch_pkg::TAG_W-1:0]    pc_tag;
    logic                           pc_aligned;

    assign pc_tag     = pc[fetch_pkg::ADDR_W-1:3];
    assign pc_aligned = (pc[1:0] == 2'b00);

    // A misaligned fetch never hits, so the trap entry carries no hit bits and no word.
    always_comb begin
        rd_word = '0;
        for (int i = 0; i < fetch_pkg::NUM_WAYS; i++) begin
            hit[i] = pc_aligned && way_valid[i] && (way_tag[i] == pc_tag);
            if (hit[i]) begin
                rd_word = way_data[i];
            end
        end
    end

    // Valid bits and the round-robin victim pointer.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            way_valid <= '0;
            victim    <= '0;
        end else if (fill_en) begin
            way_valid[victim] <= 1'b1;
            victim            <= victim + 1'b1; // Wraps from the last way to way 0.
        end
    end

    always_ff @(posedge clk) begin
        if (fill_en) begin
            way_tag[victim]  <= fill_tag;
            way_data[victim] <= fill_word;
        end
    end

endmodule

//--- fetch_pc.sv
module fetch_pc #(
    parameter logic [fetch_pkg::ADDR_W-1:0] RESET_PC = 64'h0000_0000_3000_0000
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          pc_advance,
    input  logic                          redirect,
    input  logic [fetch_pkg::ADDR_W-1:0]  redirect_pc,
    output logic [fetch_pkg::ADDR_W-1:0]  pc
);

    // A redirect wins over the sequential step.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc <= RESET_PC;
        end else if (redirect) begin
            pc <= redirect_pc;
        end else if (pc_advance) begin
            pc <= pc + 64'd4; // Next instruction.
        end
    end

endmodule

//--- fetch_pkg.sv
package fetch_pkg;

    parameter int ADDR_W   = 64;
    parameter int WORD_W   = 64;
    parameter int NUM_WAYS = 8;

    // One cache word covers eight bytes, so the tag drops the low three address bits.
    parameter int TAG_W = ADDR_W - 3;

    typedef enum logic [3:0] {
        TRAP_NOP      = 4'h0,
        TRAP_MISALIGN = 4'h1, // Fetch address is not 4-byte aligned.
        TRAP_ACCESS   = 4'h2  // Memory error reported on a refill.
    } trap_e;

    typedef enum logic [1:0] {
        ST_LOOKUP = 2'd0,
        ST_REQ    = 2'd1,
        ST_WAIT   = 2'd2
    } ctrl_state_e;

endpackage
